// ==== build.f ====
hdl/rvPkg.sv
hdl/fetchStage.sv
hdl/instDecoder.sv
hdl/decodeStage.sv
hdl/issueStage.sv
hdl/frontEndTop.sv
tb/frontEnd_props.sv
tb/frontEndTb.sv

// ==== hdl/decodeStage.sv ====
`timescale 1ns/1ns

module decodeStage
	import rvPkg::*;
(
	input  logic     clk,
	input  logic     nrst,
	input  logic     stall,
	input  word_t    pcIn,		// Fetch pc, same cycle as instrIn
	input  word_t    instrIn,	// Raw imem word
	output decoded_t decodedOut,
	output logic     decValid
);

	word_t pcReg;
	word_t instrReg;
	word_t imm;
	ctrl_t ctrl;

	// Pipe register, frozen under stall
	always_ff @(posedge clk)
	begin
		if (!stall)
		begin
			pcReg    <= pcIn;
			instrReg <= instrIn;
		end
	end

	// Valid from the first edge after reset on
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
			decValid <= 1'b0;
		else if (!stall)
			decValid <= 1'b1;
	end

	// One immediate per format
	always_comb
	begin
		case (opcode_e'(instrReg[6:0]))
			OPIMM, LOAD, JALR:	// I
				imm = {{20{instrReg[31]}}, instrReg[31:20]};
			STORE:	// S
				imm = {{20{instrReg[31]}}, instrReg[31:25], instrReg[11:7]};
			BRANCH:	// B
				imm = {{19{instrReg[31]}}, instrReg[31], instrReg[7],
					instrReg[30:25], instrReg[11:8], 1'b0};
			LUI, AUIPC:	// U
				imm = {instrReg[31:12], 12'd0};
			JAL:	// J
				imm = {{11{instrReg[31]}}, instrReg[31], instrReg[19:12],
					instrReg[20], instrReg[30:21], 1'b0};
			SYSTEM:
				imm = {20'd0, instrReg[31:20]};	// CSR address, unsigned
			default:
				imm = '0;
		endcase
	end

	instDecoder instDecoder0 (
		.instr (instrReg),
		.ctrl  (ctrl)
	);

	assign decodedOut.pc     = pcReg;
	assign decodedOut.rs1    = instrReg[19:15];
	assign decodedOut.rs2    = instrReg[24:20];
	assign decodedOut.rd     = instrReg[11:7];
	assign decodedOut.imm    = imm;
	assign decodedOut.funct3 = instrReg[14:12];	// Width or CSR op for later units
	assign decodedOut.ctrl   = ctrl;

endmodule

// ==== hdl/fetchStage.sv ====
`timescale 1ns/1ns

module fetchStage
	import rvPkg::*;
#(
	parameter word_t ResetPc = '0	// First fetch address
)
(
	input  logic  clk,
	input  logic  nrst,
	input  logic  stall,	// Hazard hold from issue
	output word_t pc		// Also the imem address
);

	localparam word_t PcStep = 32'd4;	// No compressed instructions

	word_t pcReg;
	word_t pcNext;

	// Sequential fetch only, no redirect path
	always_comb
	begin
		if (stall)
			pcNext = pcReg;	// Hold while issue is blocked
		else
			pcNext = pcReg + PcStep;
	end

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
			pcReg <= ResetPc;
		else
			pcReg <= pcNext;
	end

	// Same value goes to imem and to the decode pipe
	assign pc = pcReg;

endmodule

// ==== hdl/frontEndTop.sv ====
`timescale 1ns/1ns

module frontEndTop
	import rvPkg::*;
#(
	parameter int    NumRegs = 32,
	parameter word_t ResetPc = '0
)
(
	input  logic    clk,
	input  logic    nrst,
	input  word_t   imemData,	// Combinational imem read data
	input  logic    wbValid,
	input  regIdx_t wbRd,
	output word_t   imemAddr,
	output logic    issueValid,
	output issue_t  issueOut,
	output logic    stall
);

	decoded_t decoded;	// Decode to issue bundle
	logic     decValid;

	fetchStage #(.ResetPc(ResetPc)) fetch0 (
		.clk   (clk),
		.nrst  (nrst),
		.stall (stall),
		.pc    (imemAddr)
	);

	// pc and imem word arrive in the same cycle
	decodeStage decode0 (
		.clk        (clk),
		.nrst       (nrst),
		.stall      (stall),
		.pcIn       (imemAddr),
		.instrIn    (imemData),
		.decodedOut (decoded),
		.decValid   (decValid)
	);

	issueStage #(.NumRegs(NumRegs)) issue0 (
		.clk        (clk),
		.nrst       (nrst),
		.decValid   (decValid),
		.decodedIn  (decoded),
		.wbValid    (wbValid),
		.wbRd       (wbRd),
		.stall      (stall),
		.issueValid (issueValid),
		.issueOut   (issueOut)
	);

endmodule

// ==== hdl/instDecoder.sv ====
`timescale 1ns/1ns

module instDecoder
	import rvPkg::*;
(
	input  word_t instr,
	output ctrl_t ctrl
);

	logic [6:0]  opcode;
	logic [2:0]  funct3;
	logic [6:0]  funct7;
	logic [11:0] funct12;
	logic        bad;	// Unknown encoding

	assign opcode  = instr[6:0];
	assign funct3  = instr[14:12];
	assign funct7  = instr[31:25];
	assign funct12 = instr[31:20];

	// ALU op from funct3, alt is instr[30] where it applies
	function automatic aluFn_e aluFromFunct3(input logic [2:0] f3, input logic alt);
		aluFn_e fn;
		case (f3)
			3'd0:    fn = alt ? SUB : ADD;
			3'd1:    fn = SLL;
			3'd2:    fn = SLT;
			3'd3:    fn = SLTU;
			3'd4:    fn = XOR;
			3'd5:    fn = alt ? SRA : SRL;
			3'd6:    fn = OR;
			default: fn = AND;
		endcase
		return fn;
	endfunction

	always_comb
	begin
		ctrl        = '0;
		ctrl.aluFn  = ADD;
		ctrl.fnUnit = NONE;
		ctrl.bSel   = BSelReg;
		bad         = 1'b0;
		case (opcode_e'(opcode))
			LUI:
			begin
				ctrl.we = 1'b1; ctrl.fnUnit = ALU;
				ctrl.aluFn = PASSB;	// rd = U immediate
				ctrl.bSel = BSelImm;
				ctrl.lui = 1'b1;
			end
			AUIPC:
			begin
				ctrl.we = 1'b1; ctrl.fnUnit = ALU;
				ctrl.bSel = BSelImm;
				ctrl.auipc = 1'b1;	// Operand A is pc
			end
			JAL:
			begin
				ctrl.we = 1'b1; ctrl.fnUnit = BRU;
				ctrl.bSel = BSelPc4;
				ctrl.j = 1'b1;
			end
			JALR:
			begin
				ctrl.we = 1'b1; ctrl.fnUnit = BRU;
				ctrl.bSel = BSelPc4;
				ctrl.jr = 1'b1;
				bad = (funct3 != 3'd0);
			end
			BRANCH:
			begin
				ctrl.fnUnit = BRU;
				ctrl.btype = 1'b1;
				ctrl.bneq = funct3[0];	// BNE, BGE, BGEU flip the compare
				case (funct3[2:1])
					2'b00:   ctrl.aluFn = SUB;	// BEQ, BNE
					2'b10:   ctrl.aluFn = SLT;
					2'b11:   ctrl.aluFn = SLTU;
					default: bad = 1'b1;
				endcase
			end
			LOAD:
			begin
				ctrl.we = 1'b1; ctrl.fnUnit = LSU;
				ctrl.bSel = BSelImm;
				ctrl.memOp = {1'b0, funct3};
				bad = (funct3 == 3'd3) || (funct3 > 3'd5);
			end
			STORE:
			begin
				ctrl.fnUnit = LSU;
				ctrl.bSel = BSelImm;
				ctrl.memOp = {1'b1, funct3};
				bad = (funct3 > 3'd2);
			end
			OPIMM:
			begin
				ctrl.we = 1'b1; ctrl.fnUnit = ALU;
				ctrl.bSel = BSelImm;
				// No SUBI, bit 30 only picks SRAI
				ctrl.aluFn = aluFromFunct3(funct3, (funct3 == 3'd5) && instr[30]);
				if (funct3 == 3'd1)
					bad = (funct7 != 7'd0);
				else if (funct3 == 3'd5)
					bad = (funct7 != 7'h00) && (funct7 != 7'h20);
			end
			OP:
			begin
				ctrl.we = 1'b1;
				if (funct7 == 7'h01)
				begin
					ctrl.fnUnit = MULDIV;
					ctrl.mulDivOp = funct3;
				end
				else
				begin
					ctrl.fnUnit = ALU;
					ctrl.aluFn = aluFromFunct3(funct3, instr[30]);
					bad = !((funct7 == 7'h00) ||
						((funct7 == 7'h20) && (funct3 == 3'd0 || funct3 == 3'd5)));
				end
			end
			SYSTEM:
			begin
				if (funct3 == 3'd0 && funct12 == 12'd0)
					ctrl.ecall = 1'b1;
				else if (funct3 == 3'd4)
					bad = 1'b1;
				else
				begin
					ctrl.fnUnit = CSR;
					ctrl.we = (funct3 != 3'd0);	// Privileged returns write nothing
				end
			end
			default: bad = 1'b1;
		endcase
		// Illegal issues as a no-op flagged for the trap logic
		if (bad)
		begin
			ctrl         = '0;
			ctrl.aluFn   = ADD;
			ctrl.fnUnit  = NONE;
			ctrl.illegal = 1'b1;
		end
	end

endmodule

// ==== hdl/issueStage.sv ====
`timescale 1ns/1ns

module issueStage
	import rvPkg::*;
#(
	parameter int NumRegs = 32	// Scoreboard entries
)
(
	input  logic     clk,
	input  logic     nrst,
	input  logic     decValid,
	input  decoded_t decodedIn,
	input  logic     wbValid,	// Writeback strobe
	input  regIdx_t  wbRd,
	output logic     stall,
	output logic     issueValid,
	output issue_t   issueOut
);

	logic [NumRegs-1:0] busy;		// Pending destination per register
	logic [NumRegs-1:0] busyNext;
	logic               fire;		// Bundle moves into issue register
	logic               rs1Hit;
	logic               rs2Hit;

	// rs1 read, depends on unit and opcode flags
	function automatic logic usesRs1(input ctrl_t c, input logic [2:0] f3);
		case (c.fnUnit)
			ALU:         return !(c.lui || c.auipc);
			BRU:         return !c.j;
			LSU, MULDIV: return 1'b1;
			CSR:         return (f3 != 3'd0) && !f3[2];	// Not for CSRxI forms
			default:     return 1'b0;
		endcase
	endfunction

	function automatic logic usesRs2(input ctrl_t c);
		case (c.fnUnit)
			ALU:     return c.bSel == BSelReg;
			BRU:     return c.btype;
			LSU:     return c.memOp[3];	// Store data
			MULDIV:  return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	assign rs1Hit = usesRs1(decodedIn.ctrl, decodedIn.funct3) && busy[decodedIn.rs1];
	assign rs2Hit = usesRs2(decodedIn.ctrl) && busy[decodedIn.rs2];
	assign stall  = decValid && (rs1Hit || rs2Hit);	// RAW hazard
	assign fire   = decValid && !stall;

	// Clear first, so a same-index set overrides it
	always_comb
	begin
		busyNext = busy;
		if (wbValid)
			busyNext[wbRd] = 1'b0;
		if (fire && decodedIn.ctrl.we && decodedIn.rd != '0)
			busyNext[decodedIn.rd] = 1'b1;
	end

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			busy       <= '0;
			issueValid <= 1'b0;
		end
		else
		begin
			busy       <= busyNext;
			issueValid <= fire;	// Bubble on stall
		end
	end

	always_ff @(posedge clk)
	begin
		if (fire)
			issueOut <= decodedIn;
	end

endmodule

// ==== hdl/rvPkg.sv ====
package rvPkg;

	typedef logic [31:0] word_t;	// Data, PC and instruction word
	typedef logic [4:0]  regIdx_t;	// Architectural register index

	// RV32 major opcodes, instr[6:0]
	typedef enum logic [6:0] {
		LUI    = 7'b0110111,
		AUIPC  = 7'b0010111,
		JAL    = 7'b1101111,
		JALR   = 7'b1100111,
		BRANCH = 7'b1100011,
		LOAD   = 7'b0000011,
		STORE  = 7'b0100011,
		OPIMM  = 7'b0010011,
		OP     = 7'b0110011,
		SYSTEM = 7'b1110011
	} opcode_e;

	typedef enum logic [3:0] {
		ADD, SUB,
		SLL, SLT, SLTU,
		XOR, SRL, SRA,
		OR, AND,
		PASSB	// Operand B straight through, used by LUI
	} aluFn_e;

	typedef enum logic [2:0] {
		ALU, BRU, LSU, MULDIV, CSR, NONE
	} fnUnit_e;

	// Operand B source
	localparam logic [1:0] BSelReg = 2'd0;	// rs2
	localparam logic [1:0] BSelImm = 2'd1;	// Immediate
	localparam logic [1:0] BSelPc4 = 2'd2;	// Link value for jumps

	typedef struct packed {
		logic          we;		// Regfile write enable
		logic [1:0]    bSel;
		aluFn_e        aluFn;
		fnUnit_e       fnUnit;
		logic          bneq;	// Invert branch compare
		logic          btype;	// Conditional branch
		logic          j;		// JAL
		logic          jr;		// JALR
		logic [3:0]    memOp;	// {store, funct3}
		logic [2:0]    mulDivOp;
		logic          lui;
		logic          auipc;
		logic          ecall;
		logic          illegal;
	} ctrl_t;

	typedef struct packed {
		word_t   pc;
		regIdx_t rs1;
		regIdx_t rs2;
		regIdx_t rd;
		word_t   imm;
		logic [2:0] funct3;
		ctrl_t   ctrl;
	} decoded_t;

	typedef decoded_t issue_t;	// Issue register carries the decode bundle unchanged

endpackage

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f build.f --top-module frontEndTb -o frontEndSim
./obj_dir/frontEndSim | tee sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed, see sim.log"
	exit 1
fi

// ==== tb/frontEndTb.sv ====
`timescale 1ns/1ns

module frontEndTb
	import rvPkg::*;
();

	localparam int    ClkHalf     = 50;
	localparam int    ResetCycles = 8;
	localparam int    WaitLimit   = 20;		// Cycles per issue wait
	localparam int    SimLimit    = 200000;	// Watchdog, ns
	localparam word_t Nop         = 32'h00000013;	// addi x0, x0, 0

	logic    clk = 1'b0;
	logic    nrst = 1'b0;
	word_t   imemData = Nop;
	logic    wbValid = 1'b0;
	regIdx_t wbRd = 5'd0;
	word_t   imemAddr;
	logic    issueValid;
	issue_t  issueOut;
	logic    stall;

	word_t  imem [word_t];	// Sparse imem, unwritten words read as Nop
	word_t  prog [$];		// Program image, word i at address 4*i
	issue_t issued [$];	// Bundles in issue order
	int     gaps [$];		// Cycles between issues
	integer seed;
	int     errors;
	int     testCount;

	frontEndTop #(.NumRegs(32), .ResetPc(32'd0)) dut0 (
		.clk        (clk),
		.nrst       (nrst),
		.imemData   (imemData),
		.wbValid    (wbValid),
		.wbRd       (wbRd),
		.imemAddr   (imemAddr),
		.issueValid (issueValid),
		.issueOut   (issueOut),
		.stall      (stall)
	);

	always #ClkHalf clk = ~clk;

	// Read lands before the capturing edge
	always @(negedge clk)
		imemData <= imem.exists(imemAddr) ? imem[imemAddr] : Nop;

	initial
	begin
		#SimLimit;
		$display("Simulation time limit reached, run aborted");
		$display("SOME TESTS FAILED");
		$finish;
	end

	function automatic word_t encR(input logic [6:0] f7, input regIdx_t rs2, input regIdx_t rs1,
		input logic [2:0] f3, input regIdx_t rd, input logic [6:0] op);
		return {f7, rs2, rs1, f3, rd, op};
	endfunction

	function automatic word_t encI(input logic [11:0] imm, input regIdx_t rs1,
		input logic [2:0] f3, input regIdx_t rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	// Sign extension per format, fields packed at the top then shifted down
	function automatic word_t expectedImm(input word_t w);
		word_t imm;
		case (w[6:0])
			OPIMM, LOAD, JALR: imm = $signed(w) >>> 20;
			STORE:             imm = $signed({w[31:25], w[11:7], 20'd0}) >>> 20;
			BRANCH:            imm = $signed({w[31], w[7], w[30:25], w[11:8], 20'd0}) >>> 19;
			LUI, AUIPC:        imm = w & 32'hfffff000;
			JAL:               imm = $signed({w[31], w[19:12], w[20], w[30:21], 12'd0}) >>> 11;
			default:           imm = '0;
		endcase
		return imm;
	endfunction

	task automatic reportError(input string msg);
		$display("[FAIL] %0t ns: %s", $time, msg);
		errors++;
	endtask

	task automatic loadProgram();
		imem.delete();
		foreach (prog[i])
			imem[word_t'(4 * i)] = prog[i];
	endtask

	task automatic resetDut();
		@(negedge clk);
		nrst = 1'b0;
		wbValid = 1'b0;
		wbRd = 5'd0;
		repeat (ResetCycles) @(negedge clk);
		nrst = 1'b1;	// Released on a falling edge
	endtask

	// Next issue, sampled on falling edges
	task automatic waitIssue(output int cycles, output bit timedOut);
		cycles = 0;
		timedOut = 1'b1;
		while (timedOut && cycles < WaitLimit)
		begin
			@(negedge clk);
			cycles++;
			if (issueValid)
				timedOut = 1'b0;
		end
		if (timedOut)
		begin
			$display("Timeout: nothing issued within %0d cycles at %0t ns", WaitLimit, $time);
			errors++;
		end
	endtask

	task automatic collectIssued(input int count);
		int  k;
		int  cycles;
		bit  timedOut;
		issued.delete();
		gaps.delete();
		for (k = 0; k < count; k++)
		begin
			waitIssue(cycles, timedOut);
			if (timedOut)
				return;
			issued.push_back(issueOut);
			gaps.push_back(cycles);
			if (issueOut.pc !== word_t'(4 * k))	// Strict program order
				reportError($sformatf("issue %0d pc %h, expected %h", k, issueOut.pc, 4 * k));
		end
	endtask

	task automatic testSequence();
		int e;
		prog.delete();
		for (e = 0; e < 4; e++)
			prog.push_back(encI(12'(e + 1), 5'd0, 3'd0, regIdx_t'(e + 1), OPIMM));
		loadProgram();
		resetDut();
		if (imemAddr !== 32'd0 || issueValid !== 1'b0 || stall !== 1'b0)
			reportError($sformatf("after reset imemAddr %h issueValid %b", imemAddr, issueValid));
		for (e = 1; e <= 6; e++)
		begin
			@(negedge clk);
			if (imemAddr !== word_t'(4 * e))
				reportError($sformatf("imemAddr %h after %0d edges", imemAddr, e));
			if (e == 1 && issueValid !== 1'b0)
				reportError("issueValid high one edge after reset");
			else if (e >= 2 && (issueValid !== 1'b1 || issueOut.pc !== word_t'(4 * (e - 2))))
				reportError($sformatf("edge %0d issueValid %b pc %h", e, issueValid, issueOut.pc));
			if (e >= 2 && e <= 5 && issueOut.rd !== regIdx_t'(e - 1))
				reportError($sformatf("edge %0d rd %0d", e, issueOut.rd));
		end
	endtask

	task automatic testImmediates();
		logic [6:0] ops [5] = '{OPIMM, STORE, BRANCH, LUI, JAL};
		word_t      w;
		int         i;
		prog.delete();
		for (i = 0; i < 15; i++)
		begin
			w = $random(seed);
			w[6:0] = ops[i % 5];
			case (i % 5)
				0:       w[14:7] = 8'h00;		// addi, rd x0
				1:       w[14:12] = 3'd2;	// sw
				2:       w[14:12] = 3'd0;	// beq
				default: w[11:7] = 5'd0;		// rd x0 keeps sources free
			endcase
			prog.push_back(w);
		end
		loadProgram();
		resetDut();
		collectIssued(15);
		foreach (issued[i])
			if (issued[i].imm !== expectedImm(prog[i]))
				reportError($sformatf("instr %h imm %h, expected %h",
					prog[i], issued[i].imm, expectedImm(prog[i])));
	endtask

	task automatic testAluControl();
		aluFn_e     expFn [8]   = '{ADD, SUB, SRL, SRA, ADD, SRA, ADD, ADD};
		fnUnit_e    expUnit [8] = '{ALU, ALU, ALU, ALU, ALU, ALU, MULDIV, MULDIV};
		logic [1:0] expBSel [8] = '{BSelReg, BSelReg, BSelReg, BSelReg,
			BSelImm, BSelImm, BSelReg, BSelReg};
		logic [2:0] expMd [8]   = '{3'd0, 3'd0, 3'd0, 3'd0, 3'd0, 3'd0, 3'd0, 3'd5};
		prog.delete();
		prog.push_back(encR(7'h00, 5'd2, 5'd1, 3'd0, 5'd10, OP));		// add
		prog.push_back(encR(7'h20, 5'd2, 5'd1, 3'd0, 5'd11, OP));		// sub
		prog.push_back(encR(7'h00, 5'd2, 5'd1, 3'd5, 5'd12, OP));		// srl
		prog.push_back(encR(7'h20, 5'd2, 5'd1, 3'd5, 5'd13, OP));		// sra
		prog.push_back(encI(12'hfff, 5'd1, 3'd0, 5'd14, OPIMM));		// addi -1
		prog.push_back(encI(12'h403, 5'd1, 3'd5, 5'd15, OPIMM));		// srai 3
		prog.push_back(encR(7'h01, 5'd2, 5'd1, 3'd0, 5'd16, OP));		// mul
		prog.push_back(encR(7'h01, 5'd2, 5'd1, 3'd5, 5'd17, OP));		// divu
		loadProgram();
		resetDut();
		collectIssued(8);
		foreach (issued[i])
		begin
			if (issued[i].ctrl.fnUnit !== expUnit[i] || issued[i].ctrl.bSel !== expBSel[i])
				reportError($sformatf("instr %0d unit %0d bSel %0d", i,
					issued[i].ctrl.fnUnit, issued[i].ctrl.bSel));
			if (issued[i].ctrl.we !== 1'b1 || issued[i].ctrl.illegal !== 1'b0)
				reportError($sformatf("instr %0d we or illegal wrong", i));
			if (expUnit[i] == ALU && issued[i].ctrl.aluFn !== expFn[i])
				reportError($sformatf("instr %0d aluFn %0d, expected %0d", i,
					issued[i].ctrl.aluFn, expFn[i]));
			if (expUnit[i] == MULDIV && issued[i].ctrl.mulDivOp !== expMd[i])
				reportError($sformatf("instr %0d mulDivOp %0d", i, issued[i].ctrl.mulDivOp));
		end
	endtask

	task automatic testHazard();
		word_t held;
		int    i;
		int    cycles;
		bit    timedOut;
		prog.delete();
		prog.push_back(encI(12'd0, 5'd1, 3'd2, 5'd5, LOAD));		// lw x5
		prog.push_back(encR(7'h00, 5'd2, 5'd5, 3'd0, 5'd6, OP));	// add reads x5
		loadProgram();
		resetDut();
		waitIssue(cycles, timedOut);
		if (timedOut)
			return;
		if (issueOut.pc !== 32'd0 || issueOut.ctrl.fnUnit !== LSU)
			reportError($sformatf("load issued with pc %h", issueOut.pc));
		if (stall !== 1'b1)
			reportError("no stall for add reading pending x5");
		held = 32'd8;	// Add sits in decode, fetch one word ahead
		for (i = 0; i < 4; i++)
		begin
			@(negedge clk);
			if (stall !== 1'b1 || issueValid !== 1'b0)
				reportError($sformatf("stall %b issueValid %b while x5 pending", stall, issueValid));
			if (imemAddr !== held)
				reportError($sformatf("imemAddr moved to %h under stall", imemAddr));
		end
		wbValid = 1'b1;	// Writeback of x5
		wbRd = 5'd5;
		@(negedge clk);
		wbValid = 1'b0;
		if (issueValid !== 1'b0 || stall !== 1'b0)
			reportError($sformatf("at clear edge issueValid %b stall %b", issueValid, stall));
		waitIssue(cycles, timedOut);
		if (timedOut)
			return;
		if (cycles != 1 || issueOut.pc !== 32'd4 || issueOut.rs1 !== 5'd5)
			reportError($sformatf("add issued after %0d cycles with pc %h", cycles, issueOut.pc));
	endtask

	task automatic testNoFalseStall();
		prog.delete();
		prog.push_back(encI(12'd5, 5'd0, 3'd0, 5'd0, OPIMM));		// writes x0
		prog.push_back(encR(7'h00, 5'd0, 5'd0, 3'd0, 5'd7, OP));	// reads x0
		prog.push_back(encI(12'd4, 5'd1, 3'd2, 5'd8, LOAD));
		prog.push_back(encR(7'h00, 5'd3, 5'd2, 3'd0, 5'd9, OP));	// unrelated sources
		prog.push_back(encR(7'h20, 5'd1, 5'd4, 3'd0, 5'd11, OP));
		loadProgram();
		resetDut();
		collectIssued(5);
		foreach (gaps[k])
			if (gaps[k] != ((k == 0) ? 2 : 1))	// Back to back without stall
				reportError($sformatf("issue %0d took %0d cycles", k, gaps[k]));
	endtask

	task automatic testSystem();
		word_t w;
		prog.delete();
		prog.push_back(32'h00000073);	// ecall
		prog.push_back(encI(12'h305, 5'd1, 3'd1, 5'd12, SYSTEM));	// csrrw mtvec
		w = $random(seed);
		w[6:0] = 7'b1111111;	// Not an RV32 opcode
		prog.push_back(w);
		loadProgram();
		resetDut();
		collectIssued(3);
		if (issued.size() < 3)
			return;
		if (issued[0].ctrl.ecall !== 1'b1 || issued[0].ctrl.illegal !== 1'b0)
			reportError("ecall flag not set");
		if (issued[1].ctrl.fnUnit !== CSR || issued[1].imm !== 32'h305 || issued[1].ctrl.we !== 1'b1)
			reportError($sformatf("csr unit %0d imm %h", issued[1].ctrl.fnUnit, issued[1].imm));
		if (issued[2].ctrl.illegal !== 1'b1 || issued[2].ctrl.we !== 1'b0)
			reportError($sformatf("undefined opcode %h not flagged illegal", w));
	endtask

	task automatic finishTest(input string name, input int errorsBefore);
		testCount++;
		if (errors == errorsBefore)
			$display("%s: passed", name);
		else
			$display("%s: failed with %0d errors", name, errors - errorsBefore);
	endtask

	initial
	begin
		int mark;
		seed = 97;
		errors = 0;
		testCount = 0;
		mark = errors;
		testSequence();
		finishTest("sequence", mark);
		mark = errors;
		testImmediates();
		finishTest("immediates", mark);
		mark = errors;
		testAluControl();
		finishTest("alu and muldiv control", mark);
		mark = errors;
		testHazard();
		finishTest("hazard stall", mark);
		mark = errors;
		testNoFalseStall();
		finishTest("x0 and independent sources", mark);
		mark = errors;
		testSystem();
		finishTest("system and illegal", mark);
		$display("%0d tests run, %0d errors", testCount, errors);
		if (errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// ==== tb/frontEnd_props.sv ====
`timescale 1ns/1ns

module frontEndProps
	import rvPkg::*;
#(
	parameter int NumRegs = 32
)
(
	input logic               clk,
	input logic               nrst,
	input logic               stall,
	input logic               decValid,
	input logic               issueValid,
	input logic               wbValid,
	input decoded_t           decodedIn,
	input logic [NumRegs-1:0] busy		// Scoreboard state
);

	// A stalled edge must load a bubble
	bubbleOnStall: assert property (@(posedge clk) disable iff (!nrst) stall |=> !issueValid)
		else $error("issueValid high after a stalled edge");

	// Only a writeback can release a stall
	stallHeldUntilWb: assert property (@(posedge clk) disable iff (!nrst)
		stall && !wbValid |=> stall)
		else $error("stall dropped with no writeback");

	x0NeverBusy: assert property (@(posedge clk) disable iff (!nrst) !busy[0])
		else $error("register 0 marked busy");

	// Decode bundle frozen while fetch holds
	pairHeld: assert property (@(posedge clk) disable iff (!nrst)
		stall |=> $stable(decodedIn))
		else $error("decode pair changed across a stalled edge");

endmodule

bind issueStage frontEndProps #(.NumRegs(NumRegs)) props0 (
	.clk        (clk),
	.nrst       (nrst),
	.stall      (stall),
	.decValid   (decValid),
	.issueValid (issueValid),
	.wbValid    (wbValid),
	.decodedIn  (decodedIn),
	.busy       (busy)
);
